//--- rtl/cop_pkg.sv
package cop_pkg;

    typedef logic [31:0] word_t;       // Data word, register value, address
    typedef logic [ 3:0] cpr_addr_t;   // Coprocessor register index
    typedef logic [ 4:0] gpr_addr_t;   // CPU register index
    typedef logic [ 3:0] iclass_t;     // Instruction class field
    typedef logic [ 3:0] sclass_t;     // Instruction subclass field
    typedef logic [ 2:0] result_t;     // Instruction result code

    localparam int CLASS_LSB  = 28;    // Class in bits 31..28
    localparam int SCLASS_LSB = 24;    // Subclass in bits 27..24
    localparam int CRD_LSB    = 20;    // crd in bits 23..20
    localparam int CRS1_LSB   = 16;    // crs1 in bits 19..16
    localparam int CRS2_LSB   = 12;    // crs2 in bits 15..12
    localparam int RD_LSB     = 0;     // rd in bits 4..0
    localparam int IMM_W      = 12;    // Immediate in bits 11..0, signed

    localparam iclass_t ICLASS_ARITH     = 4'd1;
    localparam iclass_t ICLASS_MOVE      = 4'd2;
    localparam iclass_t ICLASS_LOADSTORE = 4'd3;

    localparam sclass_t SCLASS_ADD32   = 4'd0; // Arithmetic subclasses
    localparam sclass_t SCLASS_ADD16   = 4'd1;
    localparam sclass_t SCLASS_ADD8    = 4'd2;
    localparam sclass_t SCLASS_SUB     = 4'd3;
    localparam sclass_t SCLASS_XOR     = 4'd4;
    localparam sclass_t SCLASS_GPR2XCR = 4'd0; // Move subclasses
    localparam sclass_t SCLASS_XCR2GPR = 4'd1;
    localparam sclass_t SCLASS_LW      = 4'd0; // Load/store subclasses
    localparam sclass_t SCLASS_SW      = 4'd1;

    localparam result_t RES_SUCCESS = 3'd0;
    localparam result_t RES_BAD_INS = 3'd1; // Illegal encoding
    localparam result_t RES_BAD_LAD = 3'd2; // Misaligned load address
    localparam result_t RES_BAD_SAD = 3'd3; // Misaligned store address
    localparam result_t RES_LD_ERR  = 3'd4; // Bus error on load
    localparam result_t RES_ST_ERR  = 3'd5; // Bus error on store

    typedef enum logic [1:0] {
        FU_NONE,                       // Illegal, no unit runs it
        FU_PALU,                       // Arithmetic and moves
        FU_MEM                         // Loads and stores
    } fu_sel_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAITING,                    // ack high, waiting for req
        ST_EXECUTING,                  // Unit busy
        ST_FINISHED                    // rsp high, waiting for CPU ack
    } insn_state_t;

endpackage

//--- rtl/cop_insn_ctrl.sv
`timescale 1ns/10ps

module cop_insn_ctrl (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  logic               cpu_insn_req,
    output logic               cop_insn_ack,
    input  cop_pkg::word_t     cpu_insn_enc,
    input  cop_pkg::word_t     cpu_rs1,
    output logic               cop_insn_rsp,
    input  logic               cpu_insn_ack,
    output cop_pkg::word_t     insn_enc,
    output cop_pkg::word_t     insn_rs1,
    output logic               insn_valid,
    input  logic               fu_done,
    input  logic               gpr_wen,
    input  cop_pkg::gpr_addr_t gpr_waddr,
    input  cop_pkg::word_t     gpr_wdata,
    input  cop_pkg::result_t   insn_result,
    output logic               cop_wen,
    output cop_pkg::gpr_addr_t cop_waddr,
    output cop_pkg::word_t     cop_wdata,
    output cop_pkg::result_t   cop_result
);
    import cop_pkg::*;

    insn_state_t state, n_state;
    logic        n_ack, n_rsp;
    logic        insn_accept, insn_retire;
    word_t       r_insn_enc, r_rs1;        // Captured at accept

    assign insn_accept = cpu_insn_req && cop_insn_ack;
    assign insn_retire = cop_insn_rsp && cpu_insn_ack;
    assign insn_valid  = insn_accept || (state == ST_EXECUTING);

    // Pass-through in the accept cycle so single-cycle insns finish there
    assign insn_enc = insn_accept ? cpu_insn_enc : r_insn_enc;
    assign insn_rs1 = insn_accept ? cpu_rs1 : r_rs1;

    always_comb begin
        n_state = state;
        n_ack   = 1'b0;
        n_rsp   = 1'b0;
        case (state)
            ST_IDLE: begin
                n_state = ST_WAITING;
                n_ack   = 1'b1;
            end
            ST_WAITING: begin
                if (insn_accept) begin
                    n_state = fu_done ? ST_FINISHED : ST_EXECUTING; // Same-cycle finish
                    n_rsp   = fu_done;
                end else begin
                    n_ack   = 1'b1;
                end
            end
            ST_EXECUTING: begin
                if (fu_done) begin
                    n_state = ST_FINISHED;
                    n_rsp   = 1'b1;
                end
            end
            ST_FINISHED: begin
                if (insn_retire) begin
                    n_state = ST_WAITING;
                    n_ack   = 1'b1;
                end else begin
                    n_rsp   = 1'b1;                // Hold until CPU acks
                end
            end
            default: n_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state        <= ST_IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
            cop_wen      <= 1'b0;
            cop_result   <= RES_SUCCESS;
        end else begin
            state        <= n_state;
            cop_insn_ack <= n_ack;
            cop_insn_rsp <= n_rsp;
            if (fu_done) begin
                cop_wen    <= gpr_wen;
                cop_result <= insn_result;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (insn_accept) begin
            r_insn_enc <= cpu_insn_enc;
            r_rs1      <= cpu_rs1;
        end
        if (fu_done) begin
            cop_waddr <= gpr_waddr;                // Writeback payload
            cop_wdata <= gpr_wdata;
        end
    end

endmodule

//--- rtl/cop_decode.sv
`timescale 1ns/10ps

module cop_decode (
    input  cop_pkg::word_t     insn_enc,
    output cop_pkg::fu_sel_t   dec_unit,
    output logic               dec_exception,
    output cop_pkg::iclass_t   dec_class,
    output cop_pkg::sclass_t   dec_subclass,
    output cop_pkg::cpr_addr_t dec_crd,
    output cop_pkg::cpr_addr_t dec_crs1,
    output cop_pkg::cpr_addr_t dec_crs2,
    output cop_pkg::gpr_addr_t dec_rd,
    output cop_pkg::word_t     dec_imm
);
    import cop_pkg::*;

    assign dec_class    = insn_enc[CLASS_LSB +: 4];
    assign dec_subclass = insn_enc[SCLASS_LSB +: 4];
    assign dec_crd      = insn_enc[CRD_LSB +: 4];
    assign dec_crs1     = insn_enc[CRS1_LSB +: 4];
    assign dec_crs2     = insn_enc[CRS2_LSB +: 4];
    assign dec_rd       = insn_enc[RD_LSB +: 5];
    assign dec_imm      = {{(32-IMM_W){insn_enc[IMM_W-1]}}, insn_enc[IMM_W-1:0]}; // Sign extend

    always_comb begin
        dec_unit = FU_NONE;
        case (dec_class)
            ICLASS_ARITH: begin
                if (dec_subclass <= SCLASS_XOR) begin    // ADD32..XOR contiguous
                    dec_unit = FU_PALU;
                end
            end
            ICLASS_MOVE: begin
                if (dec_subclass == SCLASS_GPR2XCR || dec_subclass == SCLASS_XCR2GPR) begin
                    dec_unit = FU_PALU;
                end
            end
            ICLASS_LOADSTORE: begin
                if (dec_subclass == SCLASS_LW || dec_subclass == SCLASS_SW) begin
                    dec_unit = FU_MEM;
                end
            end
            default: dec_unit = FU_NONE;               // Unknown class
        endcase
    end

    assign dec_exception = (dec_unit == FU_NONE);

endmodule

//--- rtl/cop_cprs.sv
`timescale 1ns/10ps

module cop_cprs (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  cop_pkg::cpr_addr_t crs1_addr,
    input  cop_pkg::cpr_addr_t crs2_addr,
    output cop_pkg::word_t     crs1_rdata,
    output cop_pkg::word_t     crs2_rdata,
    input  logic               crd_wen,
    input  cop_pkg::cpr_addr_t crd_addr,
    input  cop_pkg::word_t     crd_wdata
);
    import cop_pkg::*;

    word_t regs [16];                   // 16 x 32 coprocessor registers

    // Asynchronous reads
    assign crs1_rdata = regs[crs1_addr];
    assign crs2_rdata = regs[crs2_addr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;              // Architectural zero state
            end
        end else if (crd_wen) begin
            regs[crd_addr] <= crd_wdata;
        end
    end

endmodule

//--- rtl/cop_palu.sv
`timescale 1ns/10ps

module cop_palu (
    input  logic             palu_ivalid,
    input  cop_pkg::iclass_t dec_class,
    input  cop_pkg::sclass_t dec_subclass,
    input  cop_pkg::word_t   insn_rs1,
    input  cop_pkg::word_t   palu_rs1,
    input  cop_pkg::word_t   palu_rs2,
    output logic             palu_cpr_wen,
    output cop_pkg::word_t   palu_cpr_wdata,
    output logic             palu_gpr_wen,
    output cop_pkg::word_t   palu_gpr_wdata
);
    import cop_pkg::*;

    logic [3:0] lane_cut;               // Carry break below each byte lane
    word_t      add_res;
    word_t      arith_res;
    logic       is_arith, is_gpr2xcr, is_xcr2gpr;

    assign is_arith   = (dec_class == ICLASS_ARITH);
    assign is_gpr2xcr = (dec_class == ICLASS_MOVE) && (dec_subclass == SCLASS_GPR2XCR);
    assign is_xcr2gpr = (dec_class == ICLASS_MOVE) && (dec_subclass == SCLASS_XCR2GPR);

    always_comb begin
        case (dec_subclass)
            SCLASS_ADD8:  lane_cut = 4'b1111;  // Every byte independent
            SCLASS_ADD16: lane_cut = 4'b0101;  // Halfword lanes
            default:      lane_cut = 4'b0001;  // Full 32-bit add
        endcase
    end

    // Byte-wise ripple, carry dropped at lane boundaries
    always_comb begin
        logic [8:0] lane_sum;
        logic       carry;
        carry = 1'b0;
        for (int i = 0; i < 4; i++) begin
            lane_sum         = {1'b0, palu_rs1[8*i +: 8]} + {1'b0, palu_rs2[8*i +: 8]}
                               + {8'd0, carry & ~lane_cut[i]};
            add_res[8*i +: 8] = lane_sum[7:0];
            carry             = lane_sum[8];
        end
    end

    always_comb begin
        case (dec_subclass)
            SCLASS_SUB: arith_res = palu_rs1 - palu_rs2;
            SCLASS_XOR: arith_res = palu_rs1 ^ palu_rs2;
            default:    arith_res = add_res;    // ADD32/16/8
        endcase
    end

    assign palu_cpr_wen   = palu_ivalid && (is_arith || is_gpr2xcr);
    assign palu_cpr_wdata = !palu_cpr_wen ? '0 : is_gpr2xcr ? insn_rs1 : arith_res;
    assign palu_gpr_wen   = palu_ivalid && is_xcr2gpr;
    assign palu_gpr_wdata = palu_gpr_wen ? palu_rs1 : '0;  // cpr[crs1] to rd

endmodule

//--- rtl/cop_mem.sv
`timescale 1ns/10ps

module cop_mem (
    input  logic             g_clk,
    input  logic             g_resetn,
    input  logic             mem_ivalid,
    input  cop_pkg::sclass_t dec_subclass,
    input  cop_pkg::word_t   insn_rs1,
    input  cop_pkg::word_t   dec_imm,
    input  cop_pkg::word_t   cpr_rs2,
    output logic             mem_idone,
    output cop_pkg::result_t mem_result,
    output logic             mem_cpr_wen,
    output cop_pkg::word_t   mem_cpr_wdata,
    output logic             cop_mem_cen,
    output logic             cop_mem_wen,
    output cop_pkg::word_t   cop_mem_addr,
    output cop_pkg::word_t   cop_mem_wdata,
    input  cop_pkg::word_t   cop_mem_rdata,
    input  logic             cop_mem_stall,
    input  logic             cop_mem_error
);
    import cop_pkg::*;

    word_t   addr;
    logic    is_store;
    logic    misaligned;
    logic    done_q;                    // Transfer already completed
    result_t done_code;

    assign addr       = insn_rs1 + dec_imm;
    assign is_store   = (dec_subclass == SCLASS_SW);
    assign misaligned = |addr[1:0];     // Word access only

    // Bus request, held stable through stall since operands are captured
    assign cop_mem_cen   = mem_ivalid && !misaligned && !done_q;
    assign cop_mem_wen   = mem_ivalid && is_store;
    assign cop_mem_addr  = addr;
    assign cop_mem_wdata = cpr_rs2;

    // Misaligned finishes at once, otherwise on the unstalled cycle
    assign mem_idone = mem_ivalid && !done_q && (misaligned || !cop_mem_stall);

    always_comb begin
        if (misaligned) begin
            done_code = is_store ? RES_BAD_SAD : RES_BAD_LAD;
        end else if (cop_mem_error) begin
            done_code = is_store ? RES_ST_ERR : RES_LD_ERR;
        end else begin
            done_code = RES_SUCCESS;
        end
    end

    assign mem_result    = mem_idone ? done_code : RES_SUCCESS;
    assign mem_cpr_wen   = mem_idone && !misaligned && !is_store && !cop_mem_error;
    assign mem_cpr_wdata = mem_cpr_wen ? cop_mem_rdata : '0;  // LW data to crd

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= mem_ivalid && (done_q || mem_idone); // Clear when valid drops
        end
    end

endmodule

//--- rtl/cop_top.sv
`timescale 1ns/10ps

module cop_top (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              cpu_insn_req,
    output logic              cop_insn_ack,
    input  cop_pkg::word_t    cpu_insn_enc,
    input  cop_pkg::word_t    cpu_rs1,
    output logic              cop_wen,
    output cop_pkg::gpr_addr_t cop_waddr,
    output cop_pkg::word_t    cop_wdata,
    output cop_pkg::result_t  cop_result,
    output logic              cop_insn_rsp,
    input  logic              cpu_insn_ack,
    output logic              cop_mem_cen,
    output logic              cop_mem_wen,
    output cop_pkg::word_t    cop_mem_addr,
    output cop_pkg::word_t    cop_mem_wdata,
    input  cop_pkg::word_t    cop_mem_rdata,
    input  logic              cop_mem_stall,
    input  logic              cop_mem_error
);
    import cop_pkg::*;

    word_t      insn_enc, insn_rs1;    // Current instruction and rs1
    logic       insn_valid;
    logic       fu_done;
    fu_sel_t    dec_unit;
    logic       dec_exception;
    iclass_t    dec_class;
    sclass_t    dec_subclass;
    cpr_addr_t  dec_crd, dec_crs1, dec_crs2;
    gpr_addr_t  dec_rd;
    word_t      dec_imm;
    word_t      crs1_rdata, crs2_rdata;
    logic       crd_wen;
    word_t      crd_wdata;
    logic       palu_ivalid, mem_ivalid;
    logic       palu_cpr_wen, palu_gpr_wen;
    word_t      palu_cpr_wdata, palu_gpr_wdata;
    logic       mem_idone, mem_cpr_wen;
    word_t      mem_cpr_wdata;
    result_t    mem_result, insn_result;

    // Dispatch to exactly one unit
    assign palu_ivalid = insn_valid && (dec_unit == FU_PALU);
    assign mem_ivalid  = insn_valid && (dec_unit == FU_MEM);

    // PALU and illegal insns finish in the valid cycle, memory waits for the bus
    assign fu_done = (dec_unit == FU_MEM) ? mem_idone : insn_valid;

    // Idle unit drives zeros, so OR is the mux
    assign crd_wen   = palu_cpr_wen | mem_cpr_wen;
    assign crd_wdata = palu_cpr_wdata | mem_cpr_wdata;

    assign insn_result = dec_exception ? RES_BAD_INS : mem_result; // SUCCESS when mem idle

    cop_insn_ctrl u_ctrl (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .cpu_insn_req (cpu_insn_req),
        .cop_insn_ack (cop_insn_ack),
        .cpu_insn_enc (cpu_insn_enc),
        .cpu_rs1      (cpu_rs1),
        .cop_insn_rsp (cop_insn_rsp),
        .cpu_insn_ack (cpu_insn_ack),
        .insn_enc     (insn_enc),
        .insn_rs1     (insn_rs1),
        .insn_valid   (insn_valid),
        .fu_done      (fu_done),
        .gpr_wen      (palu_gpr_wen),   // Only moves write a GPR
        .gpr_waddr    (dec_rd),
        .gpr_wdata    (palu_gpr_wdata),
        .insn_result  (insn_result),
        .cop_wen      (cop_wen),
        .cop_waddr    (cop_waddr),
        .cop_wdata    (cop_wdata),
        .cop_result   (cop_result)
    );

    cop_decode u_decode (
        .insn_enc      (insn_enc),
        .dec_unit      (dec_unit),
        .dec_exception (dec_exception),
        .dec_class     (dec_class),
        .dec_subclass  (dec_subclass),
        .dec_crd       (dec_crd),
        .dec_crs1      (dec_crs1),
        .dec_crs2      (dec_crs2),
        .dec_rd        (dec_rd),
        .dec_imm       (dec_imm)
    );

    cop_cprs u_cprs (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .crs1_addr  (dec_crs1),
        .crs2_addr  (dec_crs2),
        .crs1_rdata (crs1_rdata),
        .crs2_rdata (crs2_rdata),
        .crd_wen    (crd_wen),
        .crd_addr   (dec_crd),          // Both units write crd
        .crd_wdata  (crd_wdata)
    );

    cop_palu u_palu (
        .palu_ivalid    (palu_ivalid),
        .dec_class      (dec_class),
        .dec_subclass   (dec_subclass),
        .insn_rs1       (insn_rs1),
        .palu_rs1       (crs1_rdata),
        .palu_rs2       (crs2_rdata),
        .palu_cpr_wen   (palu_cpr_wen),
        .palu_cpr_wdata (palu_cpr_wdata),
        .palu_gpr_wen   (palu_gpr_wen),
        .palu_gpr_wdata (palu_gpr_wdata)
    );

    cop_mem u_mem (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .mem_ivalid    (mem_ivalid),
        .dec_subclass  (dec_subclass),
        .insn_rs1      (insn_rs1),
        .dec_imm       (dec_imm),
        .cpr_rs2       (crs2_rdata),     // Store data from cpr[crs2]
        .mem_idone     (mem_idone),
        .mem_result    (mem_result),
        .mem_cpr_wen   (mem_cpr_wen),
        .mem_cpr_wdata (mem_cpr_wdata),
        .cop_mem_cen   (cop_mem_cen),
        .cop_mem_wen   (cop_mem_wen),
        .cop_mem_addr  (cop_mem_addr),
        .cop_mem_wdata (cop_mem_wdata),
        .cop_mem_rdata (cop_mem_rdata),
        .cop_mem_stall (cop_mem_stall),
        .cop_mem_error (cop_mem_error)
    );

endmodule

//--- sim/cop_checker.sv
`timescale 1ns/10ps

module cop_checker (
    input logic           g_clk,
    input logic           g_resetn,
    input logic           cop_insn_ack,
    input logic           cop_insn_rsp,
    input logic           cpu_insn_ack,
    input logic           cop_mem_cen,
    input logic           cop_mem_stall,
    input cop_pkg::word_t cop_mem_addr,
    input cop_pkg::word_t cop_mem_wdata
);

    // rsp held until the CPU retires it
    rsp_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_insn_rsp && !cpu_insn_ack |=> cop_insn_rsp)
        else $error("cop_insn_rsp dropped before cpu_insn_ack");

    ack_rsp_excl: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(cop_insn_ack && cop_insn_rsp))
        else $error("cop_insn_ack and cop_insn_rsp high together");

    // Bus request frozen while memory stalls
    stall_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_mem_cen && cop_mem_stall |=>
            cop_mem_cen && $stable(cop_mem_addr) && $stable(cop_mem_wdata))
        else $error("memory request changed during stall");

    reset_quiet: assert property (@(posedge g_clk)
        !g_resetn && $past(!g_resetn) |-> !cop_insn_ack && !cop_insn_rsp && !cop_mem_cen)
        else $error("handshake output high in reset");

endmodule

//--- sim/tb_cop.sv
`timescale 1ns/10ps

module tb_cop;
    import cop_pkg::*;

    localparam int TMO = 100;           // Cycles per wait

    logic      g_clk = 1'b0;
    logic      g_resetn = 1'b0;
    logic      cpu_insn_req = 1'b0;
    logic      cpu_insn_ack = 1'b0;
    word_t     cpu_insn_enc = '0;
    word_t     cpu_rs1 = '0;
    logic      cop_insn_ack, cop_insn_rsp, cop_wen;
    gpr_addr_t cop_waddr;
    word_t     cop_wdata;
    result_t   cop_result;
    logic      cop_mem_cen, cop_mem_wen, cop_mem_stall, cop_mem_error;
    word_t     cop_mem_addr, cop_mem_wdata, cop_mem_rdata;

    word_t     mem [256];               // Memory model
    word_t     shadow_mem [256];
    word_t     shadow_cpr [16];
    int        stall_left = 0;
    int        stall_next = 0;
    int        cen_count = 0;
    int        errors = 0;
    int        checks = 0;
    int        tests = 0;
    logic      exp_wen;
    gpr_addr_t exp_waddr;
    word_t     exp_wdata;
    result_t   exp_res;

    cop_top uut (.*);

    bind cop_top cop_checker u_checker (
        .g_clk(g_clk), .g_resetn(g_resetn), .cop_insn_ack(cop_insn_ack),
        .cop_insn_rsp(cop_insn_rsp), .cpu_insn_ack(cpu_insn_ack),
        .cop_mem_cen(cop_mem_cen), .cop_mem_stall(cop_mem_stall),
        .cop_mem_addr(cop_mem_addr), .cop_mem_wdata(cop_mem_wdata)
    );

    always #2 g_clk = ~g_clk;           // 4 ns period

    assign cop_mem_stall = (stall_left != 0);
    assign cop_mem_rdata = mem[cop_mem_addr[9:2]];
    assign cop_mem_error = (cop_mem_addr >= 32'h800);   // Unmapped region

    always @(posedge g_clk) begin
        stall_next = stall_left;
        if (cop_mem_cen) begin
            cen_count++;
            if (stall_left != 0) begin
                stall_next = stall_left - 1;
            end else begin
                if (cop_mem_wen && !cop_mem_error) begin
                    mem[cop_mem_addr[9:2]] <= cop_mem_wdata;
                end
                stall_next = $urandom % 4;  // Stall for next transfer
            end
        end
    end

    always @(negedge g_clk) stall_left <= stall_next;

    function automatic word_t fill_word(input int i);
        return (i * 32'h9e3779b1) ^ 32'h00c0ffee;
    endfunction

    function automatic word_t lane_add(input word_t a, input word_t b, input int w);
        word_t       r;
        logic [63:0] m, s;
        r = '0;
        m = (64'd1 << w) - 64'd1;
        for (int i = 0; i < 32; i += w) begin
            s = ((64'(a) >> i) & m) + ((64'(b) >> i) & m);
            r = r | word_t'((s & m) << i);  // Lane carry dropped
        end
        return r;
    endfunction

    // Expected response, also advances the shadow state
    function automatic void ref_model(input word_t enc, input word_t rs1, output logic wen,
                                      output gpr_addr_t waddr, output word_t wdata,
                                      output result_t res);
        logic [3:0] cls, sc, crd, crs1, crs2;
        word_t      imm, addr, a, b;
        cls   = enc[31:28];
        sc    = enc[27:24];
        crd   = enc[23:20];
        crs1  = enc[19:16];
        crs2  = enc[15:12];
        imm   = {{20{enc[11]}}, enc[11:0]};
        a     = shadow_cpr[crs1];
        b     = shadow_cpr[crs2];
        wen   = 1'b0;
        waddr = enc[4:0];
        wdata = '0;
        res   = RES_SUCCESS;
        case (cls)
            4'd1: begin
                case (sc)
                    4'd0: shadow_cpr[crd] = lane_add(a, b, 32);
                    4'd1: shadow_cpr[crd] = lane_add(a, b, 16);
                    4'd2: shadow_cpr[crd] = lane_add(a, b, 8);
                    4'd3: shadow_cpr[crd] = a - b;
                    4'd4: shadow_cpr[crd] = a ^ b;
                    default: res = RES_BAD_INS;
                endcase
            end
            4'd2: begin
                if (sc == 4'd0) begin
                    shadow_cpr[crd] = rs1;
                end else if (sc == 4'd1) begin
                    wen   = 1'b1;
                    wdata = a;
                end else begin
                    res = RES_BAD_INS;
                end
            end
            4'd3: begin
                addr = rs1 + imm;
                if (sc > 4'd1) begin
                    res = RES_BAD_INS;
                end else if (addr[1:0] != 2'b00) begin
                    res = (sc == 4'd1) ? RES_BAD_SAD : RES_BAD_LAD;
                end else if (addr >= 32'h800) begin
                    res = (sc == 4'd1) ? RES_ST_ERR : RES_LD_ERR;
                end else if (sc == 4'd1) begin
                    shadow_mem[addr[9:2]] = b;
                end else begin
                    shadow_cpr[crd] = shadow_mem[addr[9:2]];
                end
            end
            default: res = RES_BAD_INS;
        endcase
    endfunction

    function automatic word_t mk_insn(input logic [3:0] cls, input logic [3:0] sc,
                                      input logic [3:0] crd, input logic [3:0] crs1,
                                      input logic [3:0] crs2, input logic [11:0] low);
        return {cls, sc, crd, crs1, crs2, low};
    endfunction

    // Response check at retire
    always @(posedge g_clk) begin
        if (g_resetn && cop_insn_rsp && cpu_insn_ack) begin
            checks++;
            if (cop_result !== exp_res) begin
                $display("Error: cop_result 0x%h expected 0x%h", cop_result, exp_res);
                errors++;
            end
            if (cop_wen !== exp_wen) begin
                $display("Error: cop_wen 0x%h expected 0x%h", cop_wen, exp_wen);
                errors++;
            end
            if (exp_wen && cop_waddr !== exp_waddr) begin
                $display("Error: cop_waddr 0x%h expected 0x%h", cop_waddr, exp_waddr);
                errors++;
            end
            if (exp_wen && cop_wdata !== exp_wdata) begin
                $display("Error: cop_wdata 0x%h expected 0x%h", cop_wdata, exp_wdata);
                errors++;
            end
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("Timeout waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // One full handshake, exp_lat 0 means any latency
    task automatic run_insn(input word_t enc, input word_t rs1, input int exp_lat);
        int  n;
        int  lat;
        int  dly;
        ref_model(enc, rs1, exp_wen, exp_waddr, exp_wdata, exp_res);
        @(negedge g_clk);
        cpu_insn_req = 1'b1;
        cpu_insn_enc = enc;
        cpu_rs1      = rs1;
        n = 0;
        do begin
            @(posedge g_clk);
            n++;
            if (n > TMO) abort_on_timeout("cop_insn_ack");
        end while (!cop_insn_ack);
        @(negedge g_clk);
        cpu_insn_req = 1'b0;
        cpu_insn_enc = $urandom;        // Captured copy must be used
        cpu_rs1      = $urandom;
        lat = 0;
        do begin
            @(posedge g_clk);
            lat++;
            if (lat > TMO) abort_on_timeout("cop_insn_rsp");
        end while (!cop_insn_rsp);
        if (exp_lat > 0 && lat != exp_lat) begin
            $display("cop_insn_rsp came %0d cycles after accept, expected %0d", lat, exp_lat);
            errors++;
        end
        dly = $urandom % 4;             // CPU back-pressure
        repeat (dly) @(negedge g_clk);
        @(negedge g_clk);
        cpu_insn_ack = 1'b1;
        @(posedge g_clk);
        if (!cop_insn_rsp) begin
            $display("cop_insn_rsp dropped before cpu_insn_ack");
            errors++;
        end
        @(negedge g_clk);
        cpu_insn_ack = 1'b0;
    endtask

    task automatic put_cpr(input logic [3:0] idx, input word_t val);
        run_insn(mk_insn(4'd2, 4'd0, idx, 4'd0, 4'd0, 12'd0), val, 1);
    endtask

    task automatic get_cpr(input logic [3:0] idx, input logic [4:0] rd);
        run_insn(mk_insn(4'd2, 4'd1, 4'd0, idx, 4'd0, {7'd0, rd}), '0, 1);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %s %s, %0d errors", name,
                 (errors == err_before) ? "ok" : "FAILED", errors - err_before);
    endtask

    initial begin
        int    e0;
        int    n;
        int    c0;
        word_t base;
        void'($urandom(32'h78c2));
        for (int i = 0; i < 256; i++) begin
            mem[i]        = fill_word(i);
            shadow_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 16; i++) shadow_cpr[i] = '0;

        // Reset and handshake
        e0 = errors;
        repeat (3) @(negedge g_clk);
        g_resetn = 1'b1;
        n = 0;
        do begin
            @(posedge g_clk);
            n++;
            if (n > TMO) abort_on_timeout("first cop_insn_ack");
        end while (!cop_insn_ack);
        if (n != 2) begin
            $display("cop_insn_ack rose %0d cycles after reset release, expected 2", n);
            errors++;
        end
        put_cpr(4'd1, $urandom);
        report_test("reset", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            c0 = $urandom % 16;
            put_cpr(4'(c0), $urandom);
            get_cpr(4'(c0), 5'($urandom));
        end
        report_test("moves", e0);

        e0 = errors;
        for (int sc = 0; sc < 5; sc++) begin
            for (int k = 0; k < 3; k++) begin
                put_cpr(4'd1, $urandom);
                put_cpr(4'd2, $urandom);
                run_insn(mk_insn(4'd1, 4'(sc), 4'd3, 4'd1, 4'd2, 12'd0), '0, 1);
                get_cpr(4'd3, 5'd9);
            end
        end
        report_test("arith", e0);

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            base = ($urandom % 192) * 4;
            c0   = ($urandom % 64) * 4;
            put_cpr(4'd5, $urandom);
            run_insn(mk_insn(4'd3, 4'd1, 4'd0, 4'd0, 4'd5, 12'(c0)), base, 0);
            run_insn(mk_insn(4'd3, 4'd0, 4'd6, 4'd0, 4'd0, 12'(c0)), base, 0);
            get_cpr(4'd6, 5'd4);
        end
        for (int i = 0; i < 256; i++) begin
            if (mem[i] !== shadow_mem[i]) begin
                $display("Error: mem[%0d] 0x%h expected 0x%h", i, mem[i], shadow_mem[i]);
                errors++;
            end
        end
        report_test("loadstore", e0);

        e0 = errors;
        c0 = cen_count;
        run_insn(mk_insn(4'd3, 4'd0, 4'd7, 4'd0, 4'd0, 12'd0), 32'h101, 1);
        run_insn(mk_insn(4'd3, 4'd1, 4'd0, 4'd0, 4'd7, 12'd0), 32'h102, 1);
        if (cen_count != c0) begin
            $display("cop_mem_cen pulsed for a misaligned access");
            errors++;
        end
        put_cpr(4'd7, $urandom);
        run_insn(mk_insn(4'd3, 4'd0, 4'd7, 4'd0, 4'd0, 12'h010), 32'h800, 0);
        get_cpr(4'd7, 5'd3);            // Load target unchanged
        run_insn(mk_insn(4'd3, 4'd1, 4'd0, 4'd0, 4'd7, 12'd0), 32'h900, 0);
        run_insn(mk_insn(4'hf, 4'd0, 4'd1, 4'd0, 4'd0, 12'd0), '0, 1);
        run_insn(mk_insn(4'd1, 4'd9, 4'd1, 4'd0, 4'd0, 12'd0), '0, 1);
        report_test("errors", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- cop.f
rtl/cop_pkg.sv
rtl/cop_insn_ctrl.sv
rtl/cop_decode.sv
rtl/cop_cprs.sv
rtl/cop_palu.sv
rtl/cop_mem.sv
rtl/cop_top.sv
sim/cop_checker.sv
sim/tb_cop.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cop.f --top-module tb_cop -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cop)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
